//--- dual_axil_ram_pkg.sv
`default_nettype none

package dual_axil_ram_pkg;

    // bus and memory word size
    localparam int data_width = 32;

    // one strobe bit per byte lane
    localparam int strb_width = data_width / 8;

    // axi response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // returned on a read that meets a write from the other port
    localparam logic [data_width-1:0] collision_word = 32'hdeadbeef;

    // stored word, seen either as byte lanes or as a whole
    typedef union packed {
        logic [strb_width-1:0][7:0] bytes;
        logic [data_width-1:0]      word;
    } mem_word_t;

endpackage

`default_nettype wire

//--- tdp_bram.sv
`timescale 1ns/10ps
`default_nettype none

module tdp_bram #(
    parameter int mem_addr_width = 10
) (
    input  wire                                     clk,
    input  wire                                     resetn_reg,

    // port 1
    input  wire                                     en_1,
    input  wire  [dual_axil_ram_pkg::strb_width-1:0] we_1,
    input  wire  [mem_addr_width-1:0]               addr_1,
    input  wire  [dual_axil_ram_pkg::data_width-1:0] din_1,
    output logic [dual_axil_ram_pkg::data_width-1:0] dout_1,

    // port 2
    input  wire                                     en_2,
    input  wire  [dual_axil_ram_pkg::strb_width-1:0] we_2,
    input  wire  [mem_addr_width-1:0]               addr_2,
    input  wire  [dual_axil_ram_pkg::data_width-1:0] din_2,
    output logic [dual_axil_ram_pkg::data_width-1:0] dout_2
);

    import dual_axil_ram_pkg::*;

    localparam int mem_words = 2 ** mem_addr_width;

    mem_word_t mem [mem_words];

    mem_word_t new_1;
    mem_word_t new_2;

    logic                  addr_eq;
    logic                  hazard_1;
    logic                  hazard_2;
    logic                  hazard_q_1;
    logic                  hazard_q_2;
    logic [data_width-1:0] rd_q_1;
    logic [data_width-1:0] rd_q_2;

    // cross-port write on the same word
    assign addr_eq  = addr_1 == addr_2;
    assign hazard_1 = addr_eq && en_2 && (|we_2);
    assign hazard_2 = addr_eq && en_1 && (|we_1);

    // port 1 merge of strobed bytes into the stored word
    always_comb begin
        new_1 = mem[addr_1];
        for (int i = 0; i < strb_width; i++) begin
            if (we_1[i]) begin
                new_1.bytes[i] = din_1[8*i +: 8];
            end
        end
    end

    // port 2 starts from port 1's result when both write one word,
    // so its lanes win only where its own strobe is set
    always_comb begin
        new_2 = hazard_2 ? new_1 : mem[addr_2];
        for (int i = 0; i < strb_width; i++) begin
            if (we_2[i]) begin
                new_2.bytes[i] = din_2[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_1 && (|we_1)) begin
            mem[addr_1] <= new_1;
        end
        // port 2 last, its merged word already holds port 1 lanes
        if (en_2 && (|we_2)) begin
            mem[addr_2] <= new_2;
        end
    end

    // read registers, one cycle latency
    always_ff @(posedge clk) begin
        if (resetn_reg) begin
            rd_q_1     <= '0;
            rd_q_2     <= '0;
            hazard_q_1 <= 1'b0;
            hazard_q_2 <= 1'b0;
        end else begin
            if (en_1) begin
                rd_q_1     <= new_1.word;
                hazard_q_1 <= hazard_1;
            end
            if (en_2) begin
                rd_q_2     <= new_2.word;
                hazard_q_2 <= hazard_2;
            end
        end
    end

    // marker word hides data that was being overwritten
    assign dout_1 = hazard_q_1 ? collision_word : rd_q_1;
    assign dout_2 = hazard_q_2 ? collision_word : rd_q_2;

endmodule

`default_nettype wire

//--- axil_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module axil_mem_port #(
    parameter int mem_addr_width  = 10,
    parameter int axil_addr_width = 16
) (
    input  wire                                      clk,
    input  wire                                      resetn_reg,

    // write address and data
    input  wire  [axil_addr_width-1:0]               awaddr,
    input  wire                                      awvalid,
    output logic                                     awready,
    input  wire  [dual_axil_ram_pkg::data_width-1:0] wdata,
    input  wire  [dual_axil_ram_pkg::strb_width-1:0] wstrb,
    input  wire                                      wvalid,
    output logic                                     wready,

    // write response
    output logic [1:0]                               bresp,
    output logic                                     bvalid,
    input  wire                                      bready,

    // read address
    input  wire  [axil_addr_width-1:0]               araddr,
    input  wire                                      arvalid,
    output logic                                     arready,

    // read data
    output logic [dual_axil_ram_pkg::data_width-1:0] rdata,
    output logic [1:0]                               rresp,
    output logic                                     rvalid,
    input  wire                                      rready,

    // ram port
    output logic                                     mem_en,
    output logic [dual_axil_ram_pkg::strb_width-1:0] mem_we,
    output logic [mem_addr_width-1:0]                mem_addr,
    output logic [dual_axil_ram_pkg::data_width-1:0] mem_din,
    input  wire  [dual_axil_ram_pkg::data_width-1:0] mem_dout
);

    import dual_axil_ram_pkg::*;

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_wr_resp = 2'd1;
    localparam logic [1:0] st_rd_wait = 2'd2;
    localparam logic [1:0] st_rd_resp = 2'd3;

    logic [1:0]                 state;
    logic [1:0]                 resp_q;
    logic [data_width-1:0]      rdata_q;
    logic                       idle;
    logic                       wr_accept;
    logic                       rd_accept;
    logic                       wr_in_range;
    logic                       rd_in_range;
    logic [axil_addr_width-3:0] aw_word;
    logic [axil_addr_width-3:0] ar_word;
    logic [axil_addr_width-3:0] sel_word;

    assign idle = state == st_idle;

    // write needs address and data together, and beats a read
    assign wr_accept = idle && awvalid && wvalid;
    assign rd_accept = idle && arvalid && !wr_accept;

    assign awready = wr_accept;
    assign wready  = wr_accept;
    assign arready = rd_accept;

    // word index, byte offset dropped
    assign aw_word = awaddr[axil_addr_width-1:2];
    assign ar_word = araddr[axil_addr_width-1:2];

    // in range when no bit above the memory index is set
    assign wr_in_range = (aw_word >> mem_addr_width) == '0;
    assign rd_in_range = (ar_word >> mem_addr_width) == '0;

    // ram access only in the acceptance cycle
    assign sel_word = wr_accept ? aw_word : ar_word;
    assign mem_en   = (wr_accept && wr_in_range) || (rd_accept && rd_in_range);
    assign mem_we   = (wr_accept && wr_in_range) ? wstrb : '0;
    assign mem_addr = sel_word[mem_addr_width-1:0];
    assign mem_din  = wdata;

    always_ff @(posedge clk) begin
        if (resetn_reg) begin
            state  <= st_idle;
            resp_q <= resp_okay;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_accept) begin
                        state  <= st_wr_resp;
                        resp_q <= wr_in_range ? resp_okay : resp_slverr;
                    end else if (rd_accept) begin
                        state  <= st_rd_wait;
                        resp_q <= rd_in_range ? resp_okay : resp_slverr;
                    end
                end
                st_wr_resp: begin
                    if (bready) begin
                        state <= st_idle;
                    end
                end
                // ram output registered, take it next edge
                st_rd_wait: begin
                    state <= st_rd_resp;
                end
                st_rd_resp: begin
                    if (rready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // holding register, keeps the ram free while rready is low
    always_ff @(posedge clk) begin
        if (state == st_rd_wait) begin
            rdata_q <= (resp_q == resp_okay) ? mem_dout : '0;
        end
    end

    assign bvalid = state == st_wr_resp;
    assign bresp  = resp_q;
    assign rvalid = state == st_rd_resp;
    assign rresp  = resp_q;
    assign rdata  = rdata_q;

endmodule

`default_nettype wire

//--- dual_axil_ram.sv
`timescale 1ns/10ps
`default_nettype none

module dual_axil_ram #(
    parameter int mem_addr_width  = 10,
    parameter int axil_addr_width = 16
) (
    input  wire                                      clk,
    input  wire                                      resetn_reg,

    // slave port 1
    input  wire  [axil_addr_width-1:0]               s1_awaddr,
    input  wire                                      s1_awvalid,
    output logic                                     s1_awready,
    input  wire  [dual_axil_ram_pkg::data_width-1:0] s1_wdata,
    input  wire  [dual_axil_ram_pkg::strb_width-1:0] s1_wstrb,
    input  wire                                      s1_wvalid,
    output logic                                     s1_wready,
    output logic [1:0]                               s1_bresp,
    output logic                                     s1_bvalid,
    input  wire                                      s1_bready,
    input  wire  [axil_addr_width-1:0]               s1_araddr,
    input  wire                                      s1_arvalid,
    output logic                                     s1_arready,
    output logic [dual_axil_ram_pkg::data_width-1:0] s1_rdata,
    output logic [1:0]                               s1_rresp,
    output logic                                     s1_rvalid,
    input  wire                                      s1_rready,

    // slave port 2
    input  wire  [axil_addr_width-1:0]               s2_awaddr,
    input  wire                                      s2_awvalid,
    output logic                                     s2_awready,
    input  wire  [dual_axil_ram_pkg::data_width-1:0] s2_wdata,
    input  wire  [dual_axil_ram_pkg::strb_width-1:0] s2_wstrb,
    input  wire                                      s2_wvalid,
    output logic                                     s2_wready,
    output logic [1:0]                               s2_bresp,
    output logic                                     s2_bvalid,
    input  wire                                      s2_bready,
    input  wire  [axil_addr_width-1:0]               s2_araddr,
    input  wire                                      s2_arvalid,
    output logic                                     s2_arready,
    output logic [dual_axil_ram_pkg::data_width-1:0] s2_rdata,
    output logic [1:0]                               s2_rresp,
    output logic                                     s2_rvalid,
    input  wire                                      s2_rready
);

    import dual_axil_ram_pkg::*;

    // ram side of each slave
    logic                      p1_en;
    logic [strb_width-1:0]     p1_we;
    logic [mem_addr_width-1:0] p1_addr;
    logic [data_width-1:0]     p1_din;
    logic [data_width-1:0]     p1_dout;
    logic                      p2_en;
    logic [strb_width-1:0]     p2_we;
    logic [mem_addr_width-1:0] p2_addr;
    logic [data_width-1:0]     p2_din;
    logic [data_width-1:0]     p2_dout;

    axil_mem_port #(
        .mem_addr_width (mem_addr_width),
        .axil_addr_width(axil_addr_width)
    ) u_port1 (
        .clk(clk), .resetn_reg(resetn_reg),
        .awaddr(s1_awaddr), .awvalid(s1_awvalid), .awready(s1_awready),
        .wdata(s1_wdata), .wstrb(s1_wstrb), .wvalid(s1_wvalid), .wready(s1_wready),
        .bresp(s1_bresp), .bvalid(s1_bvalid), .bready(s1_bready),
        .araddr(s1_araddr), .arvalid(s1_arvalid), .arready(s1_arready),
        .rdata(s1_rdata), .rresp(s1_rresp), .rvalid(s1_rvalid), .rready(s1_rready),
        .mem_en(p1_en), .mem_we(p1_we), .mem_addr(p1_addr),
        .mem_din(p1_din), .mem_dout(p1_dout)
    );

    axil_mem_port #(
        .mem_addr_width (mem_addr_width),
        .axil_addr_width(axil_addr_width)
    ) u_port2 (
        .clk(clk), .resetn_reg(resetn_reg),
        .awaddr(s2_awaddr), .awvalid(s2_awvalid), .awready(s2_awready),
        .wdata(s2_wdata), .wstrb(s2_wstrb), .wvalid(s2_wvalid), .wready(s2_wready),
        .bresp(s2_bresp), .bvalid(s2_bvalid), .bready(s2_bready),
        .araddr(s2_araddr), .arvalid(s2_arvalid), .arready(s2_arready),
        .rdata(s2_rdata), .rresp(s2_rresp), .rvalid(s2_rvalid), .rready(s2_rready),
        .mem_en(p2_en), .mem_we(p2_we), .mem_addr(p2_addr),
        .mem_din(p2_din), .mem_dout(p2_dout)
    );

    tdp_bram #(
        .mem_addr_width(mem_addr_width)
    ) u_bram (
        .clk(clk), .resetn_reg(resetn_reg),
        .en_1(p1_en), .we_1(p1_we), .addr_1(p1_addr), .din_1(p1_din), .dout_1(p1_dout),
        .en_2(p2_en), .we_2(p2_we), .addr_2(p2_addr), .din_2(p2_din), .dout_2(p2_dout)
    );

endmodule

`default_nettype wire

//--- tb_axil_bfm.svh
`ifndef tb_axil_bfm_svh
`define tb_axil_bfm_svh

// one write on a port, bready kept low for hold cycles once bvalid shows
task automatic axil_write(input int port, input logic [15:0] addr, input logic [31:0] data,
                          input logic [3:0] strb, output logic [1:0] resp, input int hold = 0);
    awaddr[port]  = addr;
    wdata[port]   = data;
    wstrb[port]   = strb;
    awvalid[port] = 1'b1;
    wvalid[port]  = 1'b1;
    // ready is combinational, look at it mid-cycle
    @(negedge clk);
    while (!awready[port]) @(negedge clk);
    check("wready with awready", 32'd1, {31'd0, wready[port]});
    @(posedge clk);
    #1;
    wr_accept_time[port] = $time;
    awvalid[port] = 1'b0;
    wvalid[port]  = 1'b0;
    bready[port]  = hold == 0;
    @(negedge clk);
    while (!bvalid[port]) @(negedge clk);
    resp = bresp[port];
    repeat (hold) begin
        @(negedge clk);
        check("bvalid held", 32'd1, {31'd0, bvalid[port]});
        check("bresp held", {30'd0, resp}, {30'd0, bresp[port]});
    end
    if (hold > 0) begin
        @(posedge clk);
        #1;
        bready[port] = 1'b1;
    end
    @(posedge clk);
    #1;
    wr_done_time[port] = $time;
    bready[port] = 1'b0;
endtask

// one read on a port, rready kept low for hold cycles once rvalid shows
task automatic axil_read(input int port, input logic [15:0] addr, output logic [31:0] data,
                         output logic [1:0] resp, input int hold = 0);
    araddr[port]  = addr;
    arvalid[port] = 1'b1;
    @(negedge clk);
    while (!arready[port]) @(negedge clk);
    @(posedge clk);
    #1;
    rd_accept_time[port] = $time;
    arvalid[port] = 1'b0;
    rready[port]  = hold == 0;
    @(negedge clk);
    while (!rvalid[port]) @(negedge clk);
    data = rdata[port];
    resp = rresp[port];
    repeat (hold) begin
        @(negedge clk);
        check("rvalid held", 32'd1, {31'd0, rvalid[port]});
        check("rdata held", data, rdata[port]);
        check("rresp held", {30'd0, resp}, {30'd0, rresp[port]});
    end
    if (hold > 0) begin
        @(posedge clk);
        #1;
        rready[port] = 1'b1;
    end
    @(posedge clk);
    #1;
    rd_done_time[port] = $time;
    rready[port] = 1'b0;
endtask

`endif

//--- tb_dual_axil_ram.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dual_axil_ram;

    localparam logic [31:0] marker_word = 32'hdeadbeef;
    localparam logic [1:0]  okay_resp   = 2'b00;
    localparam logic [1:0]  slverr_resp = 2'b10;
    localparam int          n_rw        = 12;
    localparam int          n_dual      = 4;
    // all transactions of all tests, forked ones included
    localparam int          n_trans     = n_rw * 5 + 16 * 3 + 2 * 4 + n_dual * 4 + 4;

    logic        clk;
    logic        resetn_reg;
    integer      seed;
    logic [15:0] awaddr  [1:2];
    logic        awvalid [1:2];
    wire         awready [1:2];
    logic [31:0] wdata   [1:2];
    logic [3:0]  wstrb   [1:2];
    logic        wvalid  [1:2];
    wire         wready  [1:2];
    wire  [1:0]  bresp   [1:2];
    wire         bvalid  [1:2];
    logic        bready  [1:2];
    logic [15:0] araddr  [1:2];
    logic        arvalid [1:2];
    wire         arready [1:2];
    wire  [31:0] rdata   [1:2];
    wire  [1:0]  rresp   [1:2];
    wire         rvalid  [1:2];
    logic        rready  [1:2];
    time         wr_accept_time [1:2];
    time         wr_done_time   [1:2];
    time         rd_accept_time [1:2];
    time         rd_done_time   [1:2];

    // byte-addressed reference memory, 4 KB
    logic [7:0]  ref_mem [0:4095];

    logic [15:0] addr;
    logic [15:0] oor_addr;
    logic [31:0] data_a;
    logic [31:0] data_b;
    logic [31:0] rd_data;
    logic [1:0]  resp_a;
    logic [1:0]  resp_b;
    logic [3:0]  strb_a;
    logic [3:0]  strb_b;
    int          hold;

    dual_axil_ram u_dut (
        .clk(clk), .resetn_reg(resetn_reg),
        .s1_awaddr(awaddr[1]), .s1_awvalid(awvalid[1]), .s1_awready(awready[1]),
        .s1_wdata(wdata[1]), .s1_wstrb(wstrb[1]), .s1_wvalid(wvalid[1]), .s1_wready(wready[1]),
        .s1_bresp(bresp[1]), .s1_bvalid(bvalid[1]), .s1_bready(bready[1]),
        .s1_araddr(araddr[1]), .s1_arvalid(arvalid[1]), .s1_arready(arready[1]),
        .s1_rdata(rdata[1]), .s1_rresp(rresp[1]), .s1_rvalid(rvalid[1]), .s1_rready(rready[1]),
        .s2_awaddr(awaddr[2]), .s2_awvalid(awvalid[2]), .s2_awready(awready[2]),
        .s2_wdata(wdata[2]), .s2_wstrb(wstrb[2]), .s2_wvalid(wvalid[2]), .s2_wready(wready[2]),
        .s2_bresp(bresp[2]), .s2_bvalid(bvalid[2]), .s2_bready(bready[2]),
        .s2_araddr(araddr[2]), .s2_arvalid(arvalid[2]), .s2_arready(arready[2]),
        .s2_rdata(rdata[2]), .s2_rresp(rresp[2]), .s2_rvalid(rvalid[2]), .s2_rready(rready[2])
    );

    `include "tb_axil_bfm.svh"

    function automatic logic [15:0] random_word_addr();
        logic [31:0] rnd;
        rnd = $random(seed);
        return {4'd0, rnd[9:0], 2'b00};
    endfunction

    // marker when the other port writes this word in the same cycle
    function automatic logic [31:0] expected_word(input logic [15:0] a, input logic other_write);
        if (other_write)
            return marker_word;
        if (a >= 16'h1000)
            return 32'd0;
        return {ref_mem[{a[11:2], 2'd3}], ref_mem[{a[11:2], 2'd2}],
                ref_mem[{a[11:2], 2'd1}], ref_mem[{a[11:2], 2'd0}]};
    endfunction

    function automatic logic [1:0] expected_resp(input logic [15:0] a);
        return (a >= 16'h1000) ? slverr_resp : okay_resp;
    endfunction

    function automatic void model_write(input logic [15:0] a, input logic [31:0] d,
                                        input logic [3:0] strb);
        for (int i = 0; i < 4; i++) begin
            if (strb[i] && a < 16'h1000) begin
                ref_mem[{a[11:2], i[1:0]}] = d[8*i +: 8];
            end
        end
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic read_and_compare(input string name, input int port, input logic [15:0] a);
        logic [31:0] d;
        logic [1:0]  r;
        axil_read(port, a, d, r);
        check(name, expected_word(a, 1'b0), d);
        check(name, {30'd0, expected_resp(a)}, {30'd0, r});
    endtask

    task automatic write_and_compare(input string name, input int port, input logic [15:0] a,
                                     input logic [31:0] d, input logic [3:0] strb);
        logic [1:0] r;
        axil_write(port, a, d, strb, r);
        check(name, {30'd0, expected_resp(a)}, {30'd0, r});
        model_write(a, d, strb);
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ends a hung run
    initial begin
        repeat (n_trans * 20 + 200) @(posedge clk);
        $display("simulation timed out");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed       = 32'h49f5f18d;
        resetn_reg = 1'b1;
        for (int p = 1; p <= 2; p++) begin
            awaddr[p]  = '0;
            awvalid[p] = 1'b0;
            wdata[p]   = '0;
            wstrb[p]   = '0;
            wvalid[p]  = 1'b0;
            bready[p]  = 1'b0;
            araddr[p]  = '0;
            arvalid[p] = 1'b0;
            rready[p]  = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1;
        resetn_reg = 1'b0;

        // no ready or valid right after reset
        for (int p = 1; p <= 2; p++) begin
            check("idle after reset", 32'd0,
                  {27'd0, awready[p], wready[p], arready[p], bvalid[p], rvalid[p]});
        end

        // write, read back, then an out-of-range alias of the same word
        for (int i = 0; i < n_rw; i++) begin
            addr     = random_word_addr();
            oor_addr = addr | {4'(1 + {$random(seed)} % 15), 12'h000};
            write_and_compare("rw write", 1, addr, $random(seed), 4'hf);
            read_and_compare("rw read port 2", 2, addr);
            write_and_compare("oor write", 1 + i % 2, oor_addr, $random(seed), 4'hf);
            read_and_compare("oor read", 2 - i % 2, oor_addr);
            read_and_compare("rw read port 1", 1, addr);
        end

        // partial writes keep the unselected bytes
        for (int s = 0; s < 16; s++) begin
            addr = random_word_addr();
            write_and_compare("strobe base", 1, addr, $random(seed), 4'hf);
            write_and_compare("strobe write", 2 - s % 2, addr, $random(seed), s[3:0]);
            read_and_compare("strobe read", 1 + s % 2, addr);
        end

        // read meets a write from the other port on the same word
        for (int r = 1; r <= 2; r++) begin
            addr   = random_word_addr();
            data_b = $random(seed);
            write_and_compare("collision setup", r, addr, $random(seed), 4'hf);
            fork
                axil_read(r, addr, rd_data, resp_a);
                axil_write(3 - r, addr, data_b, 4'hf, resp_b);
            join
            check("collision read", expected_word(addr, 1'b1), rd_data);
            check("collision read resp", {30'd0, okay_resp}, {30'd0, resp_a});
            check("collision write resp", {30'd0, okay_resp}, {30'd0, resp_b});
            model_write(addr, data_b, 4'hf);
            read_and_compare("collision readback", r, addr);
        end

        // both ports write one word, port 2 lanes win
        for (int i = 0; i < n_dual; i++) begin
            addr   = random_word_addr();
            data_a = $random(seed);
            data_b = $random(seed);
            strb_a = 4'($random(seed)) | 4'b0001;
            strb_b = 4'($random(seed)) | 4'b0001;
            write_and_compare("dual setup", 2, addr, $random(seed), 4'hf);
            fork
                axil_write(1, addr, data_a, strb_a, resp_a);
                axil_write(2, addr, data_b, strb_b, resp_b);
            join
            check("dual resp port 1", {30'd0, okay_resp}, {30'd0, resp_a});
            check("dual resp port 2", {30'd0, okay_resp}, {30'd0, resp_b});
            model_write(addr, data_a, strb_a);
            model_write(addr, data_b, strb_b);
            read_and_compare("dual read", 1, addr);
        end

        // held read response, a write on the same port has to wait
        hold   = 2 + {$random(seed)} % 12;
        data_a = $random(seed);
        data_b = expected_word(addr, 1'b0);
        fork
            axil_read(1, addr, rd_data, resp_a, hold);
            begin
                @(posedge clk);
                #1;
                axil_write(1, addr, data_a, 4'hf, resp_b);
            end
        join
        check("held read data", data_b, rd_data);
        check("held read resp", {30'd0, okay_resp}, {30'd0, resp_a});
        check("write after held read resp", {30'd0, okay_resp}, {30'd0, resp_b});
        check("write after held read", 32'd1, {31'd0, wr_accept_time[1] > rd_done_time[1]});
        model_write(addr, data_a, 4'hf);

        // held write response, a read on the same port has to wait
        data_b = $random(seed);
        fork
            axil_write(2, addr, data_b, 4'hf, resp_b, hold);
            begin
                @(posedge clk);
                #1;
                axil_read(2, addr, rd_data, resp_a);
            end
        join
        model_write(addr, data_b, 4'hf);
        check("held write resp", {30'd0, okay_resp}, {30'd0, resp_b});
        check("read after held write resp", {30'd0, okay_resp}, {30'd0, resp_a});
        check("read after held write", expected_word(addr, 1'b0), rd_data);
        check("read waits for write", 32'd1, {31'd0, rd_accept_time[2] > wr_done_time[2]});

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- dual_axil_ram.f
+incdir+.
dual_axil_ram_pkg.sv
tdp_bram.sv
axil_mem_port.sv
dual_axil_ram.sv
tb_dual_axil_ram.sv

//--- run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/10ps \
    -f dual_axil_ram.f \
    --top-module tb_dual_axil_ram \
    -o tb_dual_axil_ram

# exit status of the simulation decides pass or fail
./obj_dir/tb_dual_axil_ram
